//--- list.f
design/lockstep_pkg.sv
design/core_bus_if.sv
design/lockstep_rst_ctrl.sv
design/lockstep_in_delay.sv
design/lockstep_out_delay.sv
design/mini_core.sv
design/lockstep_cmp.sv
design/lockstep_top.sv
tb/tb_lockstep.sv

//--- run.sh
#!/bin/sh
# Build and run the lockstep checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_lockstep -o sim_lockstep
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_lockstep)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Pass only if the testbench printed its pass line
if echo "$sim_out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

//--- tb/tb_lockstep.sv
////////////////////////////////////////
// Lockstep checker testbench
// Runs a main core on a random program
// and injects faults toward the checker
////////////////////////////////////////

`timescale 1ns/10ps

module tb_lockstep;

  localparam int unsigned                     LockstepOffset = 2;
  localparam logic [lockstep_pkg::ADDR_W-1:0] IrqVector      = 16'h0100;
  localparam int unsigned                     AddrW          = lockstep_pkg::ADDR_W;
  localparam int                              RstCycles      = 5;
  // Edges from a main output to the cycle it is compared in
  localparam int                              Lag            = LockstepOffset + 1;
  localparam logic [1:0]                      ModeCheck      = 2'd0;
  localparam logic [1:0]                      ModeDiverge    = 2'd1;

  logic                             clk_i;
  logic                             rst_n;
  logic [1:0]                       mode_q;
  logic [lockstep_pkg::INSTR_W-1:0] prog [256];
  logic                             instr_rvalid  = 1'b0;
  logic [lockstep_pkg::INSTR_W-1:0] instr_rdata   = '0;
  logic                             irq           = 1'b0;
  logic                             irq_en;
  int unsigned                      gap           = 0;
  logic                             instr_req_q   = 1'b0;
  logic [AddrW-1:0]                 instr_addr_q  = '0;
  logic                             data_req_q    = 1'b0;
  logic [AddrW-1:0]                 data_addr_q   = '0;
  logic [AddrW-1:0]                 data_wdata_q  = '0;
  logic [AddrW-1:0]                 flip_mask;
  logic                             flip_cmp;
  logic                             irq_force;
  logic [Lag-1:0]                   flip_hist     = '0;
  logic                             alert;
  int                               assert_errors = 0;
  int                               timeouts;

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  core_bus_if main_bus ();

  mini_core #(
    .IrqVector(IrqVector)
  ) u_main_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_n),
    .instr_rvalid_i(instr_rvalid),
    .instr_rdata_i (instr_rdata),
    .irq_i         (irq),
    .bus           (main_bus)
  );

  // Faults are applied on the DUT side only
  lockstep_top #(
    .LockstepOffset(LockstepOffset),
    .IrqVector     (IrqVector)
  ) i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_n),
    .instr_req_i   (instr_req_q),
    .instr_addr_i  (instr_addr_q),
    .data_req_i    (data_req_q),
    .data_addr_i   (data_addr_q),
    .data_wdata_i  (data_wdata_q ^ flip_mask),
    .instr_rvalid_i(instr_rvalid),
    .instr_rdata_i (instr_rdata),
    .irq_i         (irq | irq_force),
    .alert_major_o (alert)
  );

  ////////////////////////////////////////
  // Program memory and main core outputs
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    // One-cycle fetch answer after a gap of 0 to 2 cycles
    if (main_bus.instr_req && !instr_rvalid) begin
      if (gap == 0) begin
        instr_rvalid <= 1'b1;
        instr_rdata  <= prog[main_bus.instr_addr[7:0]];
        gap          <= $urandom_range(2, 0);
      end else begin
        instr_rvalid <= 1'b0;
        gap          <= gap - 1;
      end
    end else begin
      instr_rvalid <= 1'b0;
    end
    irq          <= irq_en && ($urandom_range(63, 0) == 0);
    instr_req_q  <= main_bus.instr_req;
    instr_addr_q <= main_bus.instr_addr;
    data_req_q   <= main_bus.data_req;
    data_addr_q  <= main_bus.data_addr;
    data_wdata_q <= main_bus.data_wdata;
  end

  // Marks which cycles carried a fault that the checker must see
  always @(posedge clk_i) begin
    flip_hist <= {flip_hist[Lag-2:0], flip_cmp};
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  assert property (@(negedge clk_i) (mode_q == ModeCheck) |-> (alert == flip_hist[Lag-1]))
    else begin
      assert_errors++;
      $display("Fail at %0t: alert_major_o = %b, expected %b", $time, alert, flip_hist[Lag-1]);
    end

  // Reset clears the alert before the next clock edge
  assert property (@(posedge clk_i) !rst_n |-> !alert)
    else begin
      assert_errors++;
      $display("Fail at %0t: alert_major_o = %b, expected 0 in reset", $time, alert);
    end

  function automatic int error_count();
    error_count = assert_errors + timeouts;
  endfunction

  function automatic logic [AddrW-1:0] random_bit();
    random_bit = AddrW'(1) << $urandom_range(AddrW - 1, 0);
  endfunction

  task automatic report_test(input string name, input int errors_before);
    $display("test %s done, %0d errors", name, error_count() - errors_before);
  endtask

  task automatic wait_cycles(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk_i);
    end
  endtask

  task automatic load_program();
    logic [3:0] op;
    for (int i = 0; i < 256; i++) begin
      case ($urandom_range(3, 0))
        0: op = lockstep_pkg::OP_ADDI;
        1: op = lockstep_pkg::OP_XORI;
        2: op = lockstep_pkg::OP_STORE;
        default: op = lockstep_pkg::OP_JUMP;
      endcase
      prog[8'(i)] = {op, 12'($urandom)};
    end
  endtask

  // Faulty outputs in the last reset cycles are never compared
  task automatic reset_with_gated_flips();
    rst_n     = 1'b0;
    mode_q    = ModeCheck;
    irq_force = 1'b0;
    for (int i = 0; i < RstCycles; i++) begin
      flip_mask = (i >= RstCycles - Lag) ? random_bit() : '0;
      @(negedge clk_i);
    end
    flip_mask = '0;
    rst_n     = 1'b1;
    wait_cycles(2 * Lag);
  endtask

  task automatic clean_run(input int cycles);
    irq_en = 1'b1;
    wait_cycles(cycles);
    irq_en = 1'b0;
  endtask

  task automatic single_faults(input int count);
    for (int k = 0; k < count; k++) begin
      wait_cycles($urandom_range(20, Lag + 2));
      flip_mask = random_bit();
      flip_cmp  = 1'b1;
      @(negedge clk_i);
      flip_mask = '0;
      flip_cmp  = 1'b0;
    end
    wait_cycles(Lag + 2);
  endtask

  // Shadow core alone takes the interrupt while the main core fetches elsewhere
  task automatic irq_divergence();
    int n;
    irq_en = 1'b0;
    wait_cycles(2);
    n = 0;
    while (!(main_bus.instr_req && main_bus.instr_addr != IrqVector) && n < 50) begin
      @(negedge clk_i);
      n++;
    end
    if (!(main_bus.instr_req && main_bus.instr_addr != IrqVector)) begin
      timeouts++;
      $display("Timeout: main core never fetched away from the interrupt vector");
    end
    mode_q    = ModeDiverge;
    irq_force = 1'b1;
    @(negedge clk_i);
    irq_force = 1'b0;
    n = 0;
    while (!alert && n < 50) begin
      @(negedge clk_i);
      n++;
    end
    if (!alert) begin
      timeouts++;
      $display("Timeout: alert_major_o stayed low for 50 cycles after the irq divergence");
    end
  endtask

  initial begin
    int start;
    void'($urandom(32'h0b32_93b5));
    rst_n     = 1'b0;
    mode_q    = ModeCheck;
    irq_en    = 1'b0;
    flip_mask = '0;
    flip_cmp  = 1'b0;
    irq_force = 1'b0;
    timeouts  = 0;
    load_program();

    start = error_count();
    reset_with_gated_flips();
    report_test("start_gating", start);

    start = error_count();
    clean_run(2000);
    report_test("fault_free", start);

    start = error_count();
    single_faults(20);
    report_test("single_fault", start);

    start = error_count();
    irq_divergence();
    report_test("irq_divergence", start);

    // Reset while the alert is active, then start-up and a clean run again
    start = error_count();
    reset_with_gated_flips();
    clean_run(500);
    report_test("reset_mid_run", start);

    $display("5 tests run, %0d errors", error_count());
    if (error_count() == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- design/lockstep_top.sv
////////////////////////////////////////
// Lockstep checker top level
// Runs a delayed shadow core on the main
// core inputs and flags output mismatch
////////////////////////////////////////

`timescale 1ns/10ps

module lockstep_top #(
  parameter int unsigned                     LockstepOffset = 2,
  parameter logic [lockstep_pkg::ADDR_W-1:0] IrqVector      = 16'h0100
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Main core outputs
  input  logic                             instr_req_i,
  input  logic [lockstep_pkg::ADDR_W-1:0]  instr_addr_i,
  input  logic                             data_req_i,
  input  logic [lockstep_pkg::ADDR_W-1:0]  data_addr_i,
  input  logic [lockstep_pkg::ADDR_W-1:0]  data_wdata_i,
  // Main core inputs
  input  logic                             instr_rvalid_i,
  input  logic [lockstep_pkg::INSTR_W-1:0] instr_rdata_i,
  input  logic                             irq_i,
  output logic                             alert_major_o
);

  logic                   rst_shadow_n;
  logic                   cmp_en;
  logic                   mismatch;
  lockstep_pkg::core_in_t core_in;
  lockstep_pkg::core_in_t shadow_in;

  core_bus_if main_bus ();
  core_bus_if shadow_bus ();
  core_bus_if delayed_bus ();

  assign main_bus.instr_req  = instr_req_i;
  assign main_bus.instr_addr = instr_addr_i;
  assign main_bus.data_req   = data_req_i;
  assign main_bus.data_addr  = data_addr_i;
  assign main_bus.data_wdata = data_wdata_i;

  assign core_in.instr_rvalid = instr_rvalid_i;
  assign core_in.instr_rdata  = instr_rdata_i;
  assign core_in.irq          = irq_i;

  lockstep_rst_ctrl #(
    .LockstepOffset(LockstepOffset)
  ) u_rst_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rst_shadow_no(rst_shadow_n),
    .cmp_en_o     (cmp_en)
  );

  lockstep_in_delay #(
    .LockstepOffset(LockstepOffset)
  ) u_in_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .in_i  (core_in),
    .in_o  (shadow_in)
  );

  lockstep_out_delay #(
    .LockstepOffset(LockstepOffset)
  ) u_out_delay (
    .clk_i      (clk_i),
    .main_bus   (main_bus),
    .delayed_bus(delayed_bus)
  );

  mini_core #(
    .IrqVector(IrqVector)
  ) u_shadow_core (
    .clk_i         (clk_i),
    .rst_ni        (rst_shadow_n),
    .instr_rvalid_i(shadow_in.instr_rvalid),
    .instr_rdata_i (shadow_in.instr_rdata),
    .irq_i         (shadow_in.irq),
    .bus           (shadow_bus)
  );

  lockstep_cmp u_cmp (
    .clk_i      (clk_i),
    .cmp_en_i   (cmp_en),
    .shadow_bus (shadow_bus),
    .delayed_bus(delayed_bus),
    .mismatch_o (mismatch)
  );

  assign alert_major_o = mismatch;

endmodule

//--- design/lockstep_cmp.sv
////////////////////////////////////////
// Lockstep compare
// Registers the shadow outputs and checks
// them against the delayed main outputs
////////////////////////////////////////

`timescale 1ns/10ps

module lockstep_cmp (
  input  logic        clk_i,
  input  logic        cmp_en_i,
  core_bus_if.monitor shadow_bus,
  core_bus_if.monitor delayed_bus,
  output logic        mismatch_o
);

  localparam int unsigned BusW = 3 * lockstep_pkg::ADDR_W + 2;

  logic [BusW-1:0] shadow_d;
  logic [BusW-1:0] shadow_q;
  logic [BusW-1:0] main_dly;

  assign shadow_d = {shadow_bus.instr_req, shadow_bus.instr_addr, shadow_bus.data_req,
                     shadow_bus.data_addr, shadow_bus.data_wdata};

  assign main_dly = {delayed_bus.instr_req, delayed_bus.instr_addr, delayed_bus.data_req,
                     delayed_bus.data_addr, delayed_bus.data_wdata};

  // Shadow output register
  always_ff @(posedge clk_i) begin
    shadow_q <= shadow_d;
  end

  // All five fields are compared every cycle once enabled
  assign mismatch_o = cmp_en_i & (shadow_q != main_dly);

endmodule

//--- design/mini_core.sv
////////////////////////////////////////
// Mini accumulator core
// Fetch/execute loop with a store strobe
// and a fixed interrupt vector
////////////////////////////////////////

`timescale 1ns/10ps

module mini_core #(
  parameter logic [lockstep_pkg::ADDR_W-1:0] IrqVector = 16'h0100
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             instr_rvalid_i,
  input  logic [lockstep_pkg::INSTR_W-1:0] instr_rdata_i,
  input  logic                             irq_i,
  core_bus_if.core                         bus
);

  localparam int unsigned ImmPad = lockstep_pkg::ADDR_W - lockstep_pkg::IMM_W;

  lockstep_pkg::core_state_e        state_q, state_d;
  lockstep_pkg::core_op_e           op;
  logic [lockstep_pkg::ADDR_W-1:0]  pc_q, pc_d;
  logic [lockstep_pkg::ADDR_W-1:0]  acc_q, acc_d;
  logic [lockstep_pkg::INSTR_W-1:0] instr_q, instr_d;
  logic [lockstep_pkg::ADDR_W-1:0]  imm_ext;
  logic                             store;

  // Decode fields of the held instruction
  assign op      = lockstep_pkg::core_op_e'(instr_q[lockstep_pkg::INSTR_W-1 -: 4]);
  assign imm_ext = {{ImmPad{1'b0}}, instr_q[lockstep_pkg::IMM_W-1:0]};

  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    acc_d   = acc_q;
    instr_d = instr_q;
    store   = 1'b0;
    case (state_q)
      lockstep_pkg::FETCH: begin
        // Interrupt wins over a returning fetch
        if (irq_i) begin
          pc_d = IrqVector;
        end else if (instr_rvalid_i) begin
          instr_d = instr_rdata_i;
          state_d = lockstep_pkg::EXEC;
        end
      end
      default: begin
        state_d = lockstep_pkg::FETCH;
        pc_d    = pc_q + 1'b1;
        case (op)
          lockstep_pkg::OP_ADDI:  acc_d = acc_q + imm_ext;
          lockstep_pkg::OP_XORI:  acc_d = acc_q ^ imm_ext;
          lockstep_pkg::OP_STORE: store = 1'b1;
          lockstep_pkg::OP_JUMP:  pc_d  = imm_ext;
          default: ;
        endcase
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lockstep_pkg::FETCH;
      pc_q    <= '0;
      acc_q   <= '0;
      instr_q <= '0;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
      acc_q   <= acc_d;
      instr_q <= instr_d;
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  assign bus.instr_req  = (state_q == lockstep_pkg::FETCH);
  assign bus.instr_addr = pc_q;
  assign bus.data_req   = store;
  assign bus.data_addr  = imm_ext;
  assign bus.data_wdata = acc_q;

  // Store comes from an executed instruction and lasts one cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus.data_req |-> (state_q == lockstep_pkg::EXEC) ##1 !bus.data_req);

endmodule

//--- design/lockstep_out_delay.sv
////////////////////////////////////////
// Lockstep output delay
// Delays the main core outputs to line up
// with the registered shadow outputs
////////////////////////////////////////

`timescale 1ns/10ps

module lockstep_out_delay #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic            clk_i,
  core_bus_if.monitor     main_bus,
  core_bus_if.core        delayed_bus
);

  localparam int unsigned Depth = LockstepOffset + 1;
  localparam int unsigned BusW  = 3 * lockstep_pkg::ADDR_W + 2;

  logic [BusW-1:0] bus_in;
  logic [BusW-1:0] stage_q [Depth];

  assign bus_in = {main_bus.instr_req, main_bus.instr_addr, main_bus.data_req,
                   main_bus.data_addr, main_bus.data_wdata};

  // Extra stage covers the shadow output register
  always_ff @(posedge clk_i) begin
    for (int unsigned i = 0; i < Depth - 1; i++) begin
      stage_q[i] <= stage_q[i+1];
    end
    stage_q[Depth-1] <= bus_in;
  end

  assign {delayed_bus.instr_req, delayed_bus.instr_addr, delayed_bus.data_req,
          delayed_bus.data_addr, delayed_bus.data_wdata} = stage_q[0];

endmodule

//--- design/lockstep_in_delay.sv
////////////////////////////////////////
// Lockstep input delay
// Delays the main core inputs by the
// lockstep offset for the shadow core
////////////////////////////////////////

`timescale 1ns/10ps

module lockstep_in_delay #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lockstep_pkg::core_in_t in_i,
  output lockstep_pkg::core_in_t in_o
);

  // Entry 0 is the oldest, new inputs enter at the top
  lockstep_pkg::core_in_t [LockstepOffset-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_q <= '0;
    end else begin
      for (int unsigned i = 0; i < LockstepOffset - 1; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[LockstepOffset-1] <= in_i;
    end
  end

  // Shadow core sees the inputs in the same cycle relation as the main core
  assign in_o = stage_q[0];

endmodule

//--- design/lockstep_rst_ctrl.sv
////////////////////////////////////////
// Lockstep reset control
// Holds the shadow core in reset for the
// lockstep offset, then enables compare
////////////////////////////////////////

`timescale 1ns/10ps

module lockstep_rst_ctrl #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic rst_shadow_no,
  output logic cmp_en_o
);

  localparam int unsigned CntW = $clog2(LockstepOffset);

  logic [CntW-1:0] cnt_q;
  logic            set_d;
  logic            set_q;

  // Counter stops once the offset has been counted off
  assign set_d = (cnt_q == CntW'(LockstepOffset - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q    <= '0;
      set_q    <= 1'b0;
      cmp_en_o <= 1'b0;
    end else begin
      if (!set_d) begin
        cnt_q <= cnt_q + 1'b1;
      end
      set_q    <= set_d;
      // Compare starts one cycle after the shadow core leaves reset
      cmp_en_o <= set_q;
    end
  end

  // Shadow reset is released synchronously by a flop
  assign rst_shadow_no = set_q;

  // Compare is only on once the shadow core has run a full cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmp_en_o |-> rst_shadow_no && $past(rst_shadow_no));

endmodule

//--- design/core_bus_if.sv
////////////////////////////////////////
// Core output bus
// Fetch request and store strobe signals
////////////////////////////////////////

`timescale 1ns/10ps

interface core_bus_if;

  logic                            instr_req;
  logic [lockstep_pkg::ADDR_W-1:0] instr_addr;
  logic                            data_req;
  logic [lockstep_pkg::ADDR_W-1:0] data_addr;
  logic [lockstep_pkg::ADDR_W-1:0] data_wdata;

  modport core (output instr_req, instr_addr, data_req, data_addr, data_wdata);

  modport monitor (input instr_req, instr_addr, data_req, data_addr, data_wdata);

endinterface

//--- design/lockstep_pkg.sv
////////////////////////////////////////
// Lockstep checker shared definitions
// Widths, core state and opcode types,
// and the bundle of delayed core inputs
////////////////////////////////////////

package lockstep_pkg;

  // Address and data share one width
  localparam int unsigned ADDR_W  = 16;
  localparam int unsigned INSTR_W = 16;
  localparam int unsigned IMM_W   = 12;

  typedef enum logic {
    FETCH = 1'b0,
    EXEC  = 1'b1
  } core_state_e;

  // Opcode sits in instruction bits 15:12, unlisted codes are no-ops
  typedef enum logic [3:0] {
    OP_ADDI  = 4'h1,
    OP_XORI  = 4'h2,
    OP_STORE = 4'h3,
    OP_JUMP  = 4'h4
  } core_op_e;

  // Inputs the shadow core sees through the delay line
  typedef struct packed {
    logic               instr_rvalid;
    logic [INSTR_W-1:0] instr_rdata;
    logic               irq;
  } core_in_t;

endpackage
